/* verilog.f */
+incdir+source
source/dfd_preview_pkg.sv
source/host_command_decoder.sv
source/pixel_coord_tracker.sv
source/roi_cropper.sv
source/frame_serializer.sv
source/dfd_preview_top.sv
tests/tb_dfd_preview.sv

/* Bender.yml */
package:
  name: dfd_preview

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/dfd_preview_pkg.sv
      - source/host_command_decoder.sv
      - source/pixel_coord_tracker.sv
      - source/roi_cropper.sv
      - source/frame_serializer.sv
      - source/dfd_preview_top.sv
  - target: test
    files:
      - tests/tb_dfd_preview.sv

/* tests/tb_dfd_preview.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dfd_preview;
    import dfd_preview_pkg::*;

    localparam int          RAW_W       = 16;
    localparam int          RAW_H       = 12;
    localparam int          ROI_W       = 8;
    localparam int          ROI_H       = 6;
    localparam int          CLK_PERIOD  = 40;
    localparam int          NUM_FRAMES  = 4;
    localparam int          WATCHDOG_NS = NUM_FRAMES * RAW_W * RAW_H * 4 * 2 * CLK_PERIOD + 20000;
    localparam logic [31:0] SEED        = 32'h63cc7def;
    localparam logic [63:0] MAGIC       = "BIVFRAME";

    logic        core_clk;
    logic        sys_reset;
    logic [7:0]  host_byte_i;
    logic        host_byte_valid_i;
    pixel_pair_t pix_i;
    logic        pix_valid_i;
    logic        pix_sof_i;
    logic [7:0]  out_byte_o;
    logic        out_valid_o;
    logic        out_stall_i;
    logic        overflow_o;

    logic [31:0] stim_state;
    logic [31:0] stall_state;
    logic [7:0]  exp_q[$];
    logic [7:0]  exp_byte;
    int          model_col;
    int          model_row;
    logic        model_chan;
    int          error_count;
    int          byte_count;

    dfd_preview_top #(
        .RAW_WIDTH  (RAW_W),
        .RAW_HEIGHT (RAW_H),
        .ROI_WIDTH  (ROI_W),
        .ROI_HEIGHT (ROI_H)
    ) u_dfd_preview_top (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i),
        .pix_i             (pix_i),
        .pix_valid_i       (pix_valid_i),
        .pix_sof_i         (pix_sof_i),
        .out_byte_o        (out_byte_o),
        .out_valid_o       (out_valid_o),
        .out_stall_i       (out_stall_i),
        .overflow_o        (overflow_o)
    );

    ////////////////////
    // helpers

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ch0 of the raw test pattern
    function automatic logic [7:0] raw_ch0(input int col, input int row);
        return 8'((row * 16 + col) % 256);
    endfunction

    task automatic drive_idle();
        @(posedge core_clk);
        pix_valid_i       <= 1'b0;
        pix_sof_i         <= 1'b0;
        host_byte_valid_i <= 1'b0;
    endtask

    // roughly one idle cycle in four
    task automatic skip_random_gaps();
        stim_state = lcg_step(stim_state);
        while (stim_state[31:30] == 2'b00) begin
            drive_idle();
            stim_state = lcg_step(stim_state);
        end
    endtask

    task automatic expect_frame();
        logic [7:0] v;
        for (int i = 7; i >= 0; i--) begin
            exp_q.push_back(MAGIC[i*8 +: 8]);
        end
        for (int r = 0; r < RAW_H; r++) begin
            for (int c = 0; c < RAW_W; c++) begin
                if (c >= model_col && c < model_col + ROI_W &&
                    r >= model_row && r < model_row + ROI_H) begin
                    v = raw_ch0(c, r);
                    exp_q.push_back(model_chan ? (v ^ 8'hA5) : v);
                end
            end
        end
    endtask

    task automatic send_frame();
        expect_frame();
        for (int r = 0; r < RAW_H; r++) begin
            for (int c = 0; c < RAW_W; c++) begin
                skip_random_gaps();
                @(posedge core_clk);
                pix_i.ch0   <= raw_ch0(c, r);
                pix_i.ch1   <= raw_ch0(c, r) ^ 8'hA5;
                pix_valid_i <= 1'b1;
                pix_sof_i   <= (r == 0 && c == 0);
            end
        end
        repeat (20) drive_idle();
    endtask

    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd;
        cmd = {addr, data};
        for (int i = 5; i >= 0; i--) begin
            skip_random_gaps();
            @(posedge core_clk);
            host_byte_i       <= cmd[i*8 +: 8];
            host_byte_valid_i <= 1'b1;
        end
        drive_idle();
        // unknown addresses leave the model unchanged
        case (addr)
            16'h0010: model_col = int'(data[15:0]);
            16'h0011: model_row = int'(data[15:0]);
            16'h0012: model_chan = data[0];
            default: ;
        endcase
    endtask

    ////////////////////
    // clock, stall and watchdog

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        stall_state <= lcg_step(stall_state);
        out_stall_i <= !sys_reset && (stall_state[31:30] == 2'b00);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, %0d expected bytes never arrived, %0d errors",
                 WATCHDOG_NS, exp_q.size(), error_count);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////
    // checks

    stall_respected: assert property (@(posedge core_clk) disable iff (sys_reset)
        !(out_valid_o && out_stall_i))
        else begin
            error_count++;
            $display("[ERROR] %0t: out_valid_o high while out_stall_i high", $time);
        end

    no_overflow: assert property (@(posedge core_clk) disable iff (sys_reset) !overflow_o)
        else begin
            error_count++;
            $display("[ERROR] %0t: overflow_o set", $time);
        end

    always @(posedge core_clk) begin
        if (!sys_reset && out_valid_o) begin
            byte_expected: assert (exp_q.size() > 0)
                else begin
                    error_count++;
                    $display("[ERROR] %0t: unexpected output byte 0x%02h", $time, out_byte_o);
                end
            if (exp_q.size() > 0) begin
                exp_byte = exp_q.pop_front();
                byte_matches: assert (out_byte_o == exp_byte)
                    else begin
                        error_count++;
                        $display("[ERROR] %0t: out_byte_o 0x%02h, expected 0x%02h",
                                 $time, out_byte_o, exp_byte);
                    end
                byte_count++;
            end
        end
    end

    ////////////////////
    // test sequence

    initial begin
        sys_reset         = 1'b1;
        host_byte_i       = '0;
        host_byte_valid_i = 1'b0;
        pix_i             = '0;
        pix_valid_i       = 1'b0;
        pix_sof_i         = 1'b0;
        out_stall_i       = 1'b0;
        stim_state        = SEED;
        stall_state       = lcg_step(SEED);
        model_col         = (RAW_W - ROI_W) / 2;
        model_row         = 0;
        model_chan        = 1'b0;
        error_count       = 0;
        byte_count        = 0;
        repeat (16) @(posedge core_clk);
        sys_reset <= 1'b0;
        repeat (20) drive_idle();

        // default window at column 4, row 0
        send_frame();
        // new window while frame 1 still drains
        send_command(16'h0010, 32'd2);
        send_command(16'h0011, 32'd3);
        send_command(16'h0012, 32'd1);
        repeat (20) drive_idle();
        send_frame();
        send_command(16'h0013, 32'h0000_0006);
        repeat (20) drive_idle();
        send_frame();
        // bottom right corner of the raw frame
        send_command(16'h0010, 32'd8);
        send_command(16'h0011, 32'd6);
        send_command(16'h0012, 32'd0);
        repeat (20) drive_idle();
        send_frame();

        while (exp_q.size() != 0) begin
            @(posedge core_clk);
        end
        repeat (20) @(posedge core_clk);
        $display("checked %0d output bytes, %0d errors", byte_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/dfd_preview_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dfd_preview_cfg.svh"

module dfd_preview_top #(
    parameter int RAW_WIDTH  = `DFD_RAW_WIDTH,
    parameter int RAW_HEIGHT = `DFD_RAW_HEIGHT,
    parameter int ROI_WIDTH  = `DFD_ROI_WIDTH,
    parameter int ROI_HEIGHT = `DFD_ROI_HEIGHT
) (
    input  wire                          core_clk,
    input  wire                          sys_reset,
    // host command bytes
    input  wire [`DFD_PIXEL_W-1:0]       host_byte_i,
    input  wire                          host_byte_valid_i,
    // raw pixel pairs from both cameras
    input  wire dfd_preview_pkg::pixel_pair_t pix_i,
    input  wire                          pix_valid_i,
    input  wire                          pix_sof_i,
    // preview byte stream
    output logic [`DFD_PIXEL_W-1:0]      out_byte_o,
    output logic                         out_valid_o,
    input  wire                          out_stall_i,
    output logic                         overflow_o
);
    import dfd_preview_pkg::*;

    roi_cfg_t   roi_cfg_w;
    pix_beat_t  beat_w;
    logic       beat_valid_w;
    crop_beat_t crop_w;
    logic       crop_valid_w;

    ////////////////////
    // decode

    host_command_decoder #(
        .RAW_WIDTH (RAW_WIDTH),
        .ROI_WIDTH (ROI_WIDTH)
    ) u_host_command_decoder (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i),
        .roi_cfg_o         (roi_cfg_w)
    );

    pixel_coord_tracker #(
        .RAW_WIDTH  (RAW_WIDTH),
        .RAW_HEIGHT (RAW_HEIGHT)
    ) u_pixel_coord_tracker (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pix_i        (pix_i),
        .pix_valid_i  (pix_valid_i),
        .pix_sof_i    (pix_sof_i),
        .beat_o       (beat_w),
        .beat_valid_o (beat_valid_w)
    );

    ////////////////////
    // crop and serialize

    roi_cropper #(
        .ROI_WIDTH  (ROI_WIDTH),
        .ROI_HEIGHT (ROI_HEIGHT)
    ) u_roi_cropper (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .roi_cfg_i    (roi_cfg_w),
        .beat_i       (beat_w),
        .beat_valid_i (beat_valid_w),
        .crop_o       (crop_w),
        .crop_valid_o (crop_valid_w)
    );

    frame_serializer u_frame_serializer (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .crop_i       (crop_w),
        .crop_valid_i (crop_valid_w),
        .out_stall_i  (out_stall_i),
        .out_byte_o   (out_byte_o),
        .out_valid_o  (out_valid_o),
        .overflow_o   (overflow_o)
    );

endmodule

`default_nettype wire

/* source/frame_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dfd_preview_cfg.svh"

module frame_serializer (
    input  wire                          core_clk,
    input  wire                          sys_reset,
    input  wire dfd_preview_pkg::crop_beat_t crop_i,
    input  wire                          crop_valid_i,
    input  wire                          out_stall_i,
    output logic [`DFD_PIXEL_W-1:0]      out_byte_o,
    output logic                         out_valid_o,
    output logic                         overflow_o
);
    import dfd_preview_pkg::*;

    localparam int          DEPTH     = `DFD_FIFO_DEPTH;
    localparam int          AW        = $clog2(DEPTH);
    localparam logic [63:0] MAGIC     = `DFD_MAGIC;
    localparam int          HDR_BYTES = $bits(MAGIC) / 8;
    localparam int          IDX_W     = $clog2(HDR_BYTES + 1);

    crop_beat_t              mem [DEPTH];
    logic [AW:0]             wr_ptr_q;
    logic [AW:0]             rd_ptr_q;
    logic                    empty;
    logic                    full;
    logic                    push;
    logic                    pop;
    crop_beat_t              head;
    ser_state_e              state_q;
    logic [IDX_W-1:0]        hdr_idx_q;
    logic [`DFD_PIXEL_W-1:0] hold_q;
    logic [`DFD_PIXEL_W-1:0] magic_byte;
    logic                    have_byte;
    logic                    overflow_q;

    ////////////////////
    // beat FIFO

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign push  = crop_valid_i && !full;
    assign head  = mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr_q[AW-1:0]] <= crop_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_q <= 1'b0;
        end else begin
            wr_ptr_q   <= wr_ptr_q + push;
            rd_ptr_q   <= rd_ptr_q + pop;
            // sticky until reset
            overflow_q <= overflow_q || (crop_valid_i && full);
        end
    end

    ////////////////////
    // output select

    assign magic_byte = MAGIC[(HDR_BYTES - 1 - int'(hdr_idx_q[IDX_W-2:0])) * 8 +: 8];

    always_comb begin
        if (state_q == SER_HEADER) begin
            have_byte  = 1'b1;
            // slot after the magic carries the held corner pixel
            out_byte_o = (hdr_idx_q == IDX_W'(HDR_BYTES)) ? hold_q : magic_byte;
        end else begin
            have_byte  = !empty && !head.frame_start && (state_q == SER_PIXELS);
            out_byte_o = head.pixel;
        end
    end

    assign out_valid_o = have_byte && !out_stall_i;

    // frame starts and stray pixels in idle leave without a transfer
    assign pop = !empty && (state_q != SER_HEADER) &&
                 (head.frame_start || (state_q == SER_IDLE) || out_valid_o);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q   <= SER_IDLE;
            hdr_idx_q <= '0;
        end else if (state_q == SER_HEADER) begin
            if (out_valid_o) begin
                if (hdr_idx_q == IDX_W'(HDR_BYTES)) begin
                    state_q <= SER_PIXELS;
                end else begin
                    hdr_idx_q <= hdr_idx_q + 1'b1;
                end
            end
        end else if (pop && head.frame_start) begin
            state_q   <= SER_HEADER;
            hdr_idx_q <= '0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (pop && head.frame_start) begin
            hold_q <= head.pixel;
        end
    end

    assign overflow_o = overflow_q;

endmodule

`default_nettype wire

/* source/roi_cropper.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dfd_preview_cfg.svh"

module roi_cropper #(
    parameter int ROI_WIDTH  = `DFD_ROI_WIDTH,
    parameter int ROI_HEIGHT = `DFD_ROI_HEIGHT
) (
    input  wire                          core_clk,
    input  wire                          sys_reset,
    input  wire dfd_preview_pkg::roi_cfg_t  roi_cfg_i,
    input  wire dfd_preview_pkg::pix_beat_t beat_i,
    input  wire                          beat_valid_i,
    output dfd_preview_pkg::crop_beat_t  crop_o,
    output logic                         crop_valid_o
);
    import dfd_preview_pkg::*;

    roi_cfg_t   cfg_q;
    roi_cfg_t   cfg_w;
    logic       col_in;
    logic       row_in;
    crop_beat_t crop_q;
    logic       crop_valid_q;

    ////////////////////
    // window compare

    // the sof pixel already sees the newly latched window
    assign cfg_w  = (beat_valid_i && beat_i.sof) ? roi_cfg_i : cfg_q;
    assign col_in = (beat_i.col >= cfg_w.col) && (beat_i.col < cfg_w.col + ROI_WIDTH);
    assign row_in = (beat_i.row >= cfg_w.row) && (beat_i.row < cfg_w.row + ROI_HEIGHT);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            cfg_q        <= '0;
            crop_valid_q <= 1'b0;
        end else begin
            cfg_q        <= cfg_w;
            crop_valid_q <= beat_valid_i && col_in && row_in;
        end
    end

    always_ff @(posedge core_clk) begin
        if (beat_valid_i) begin
            crop_q.pixel       <= cfg_w.chan_sel ? beat_i.pix.ch1 : beat_i.pix.ch0;
            crop_q.frame_start <= (beat_i.col == cfg_w.col) && (beat_i.row == cfg_w.row);
        end
    end

    assign crop_o       = crop_q;
    assign crop_valid_o = crop_valid_q;

endmodule

`default_nettype wire

/* source/pixel_coord_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dfd_preview_cfg.svh"

module pixel_coord_tracker #(
    parameter int RAW_WIDTH  = `DFD_RAW_WIDTH,
    parameter int RAW_HEIGHT = `DFD_RAW_HEIGHT
) (
    input  wire                          core_clk,
    input  wire                          sys_reset,
    input  wire dfd_preview_pkg::pixel_pair_t pix_i,
    input  wire                          pix_valid_i,
    input  wire                          pix_sof_i,
    output dfd_preview_pkg::pix_beat_t   beat_o,
    output logic                         beat_valid_o
);
    import dfd_preview_pkg::*;

    // coordinates of the next expected pixel
    logic [`DFD_COORD_W-1:0] col_q;
    logic [`DFD_COORD_W-1:0] row_q;
    logic [`DFD_COORD_W-1:0] cur_col;
    logic [`DFD_COORD_W-1:0] cur_row;
    pix_beat_t               beat_q;
    logic                    beat_valid_q;

    // sof forces the current pixel to the origin
    assign cur_col = pix_sof_i ? '0 : col_q;
    assign cur_row = pix_sof_i ? '0 : row_q;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q        <= '0;
            row_q        <= '0;
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= pix_valid_i;
            if (pix_valid_i) begin
                if (cur_col == RAW_WIDTH - 1) begin
                    col_q <= '0;
                    row_q <= (cur_row == RAW_HEIGHT - 1) ? '0 : cur_row + 1'b1;
                end else begin
                    col_q <= cur_col + 1'b1;
                    row_q <= cur_row;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (pix_valid_i) begin
            beat_q.pix <= pix_i;
            beat_q.col <= cur_col;
            beat_q.row <= cur_row;
            beat_q.sof <= pix_sof_i;
        end
    end

    assign beat_o       = beat_q;
    assign beat_valid_o = beat_valid_q;

endmodule

`default_nettype wire

/* source/host_command_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dfd_preview_cfg.svh"

module host_command_decoder #(
    parameter int RAW_WIDTH = `DFD_RAW_WIDTH,
    parameter int ROI_WIDTH = `DFD_ROI_WIDTH
) (
    input  wire                          core_clk,
    input  wire                          sys_reset,
    input  wire [`DFD_PIXEL_W-1:0]       host_byte_i,
    input  wire                          host_byte_valid_i,
    output dfd_preview_pkg::roi_cfg_t    roi_cfg_o
);
    import dfd_preview_pkg::*;

    localparam int COORD_W   = `DFD_COORD_W;
    localparam int LAST_BYTE = `DFD_CMD_BYTES - 1;
    localparam int CNT_W     = $clog2(`DFD_CMD_BYTES);
    localparam int SHIFT_W   = $bits(cmd_t) - `DFD_PIXEL_W;

    // window centred horizontally by default
    localparam logic [COORD_W-1:0] DEFAULT_COL = COORD_W'((RAW_WIDTH - ROI_WIDTH) / 2);

    logic [CNT_W-1:0]   byte_cnt_q;
    logic [SHIFT_W-1:0] shift_q;
    cmd_t               cmd_w;
    logic               cmd_done;
    roi_cfg_t           cfg_q;

    ////////////////////
    // byte assembly

    // the sixth byte completes the command in the same cycle
    assign cmd_w    = {shift_q, host_byte_i};
    assign cmd_done = host_byte_valid_i && (byte_cnt_q == CNT_W'(LAST_BYTE));

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q <= '0;
        end else if (host_byte_valid_i) begin
            if (cmd_done) begin
                byte_cnt_q <= '0;
            end else begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (host_byte_valid_i) begin
            shift_q <= cmd_w[SHIFT_W-1:0];
        end
    end

    ////////////////////
    // register file

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            cfg_q.col      <= DEFAULT_COL;
            cfg_q.row      <= '0;
            cfg_q.chan_sel <= 1'b0;
        end else if (cmd_done) begin
            case (cmd_w.addr)
                ROI_COL_ADDR:     cfg_q.col      <= cmd_w.data[COORD_W-1:0];
                ROI_ROW_ADDR:     cfg_q.row      <= cmd_w.data[COORD_W-1:0];
                CHANNEL_SEL_ADDR: cfg_q.chan_sel <= cmd_w.data[0];
                // unknown addresses fall through untouched
                default: ;
            endcase
        end
    end

    assign roi_cfg_o = cfg_q;

endmodule

`default_nettype wire

/* source/dfd_preview_pkg.sv */
`default_nettype none

`include "dfd_preview_cfg.svh"

package dfd_preview_pkg;

    // host command with the address in the upper two bytes
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } cmd_t;

    typedef enum logic [15:0] {
        ROI_COL_ADDR     = 16'h0010,
        ROI_ROW_ADDR     = 16'h0011,
        CHANNEL_SEL_ADDR = 16'h0012
    } cmd_addr_e;

    // one byte per camera
    typedef struct packed {
        logic [`DFD_PIXEL_W-1:0] ch0;
        logic [`DFD_PIXEL_W-1:0] ch1;
    } pixel_pair_t;

    typedef struct packed {
        logic [`DFD_COORD_W-1:0] col;
        logic [`DFD_COORD_W-1:0] row;
        logic                    chan_sel;
    } roi_cfg_t;

    typedef struct packed {
        pixel_pair_t             pix;
        logic [`DFD_COORD_W-1:0] col;
        logic [`DFD_COORD_W-1:0] row;
        logic                    sof;
    } pix_beat_t;

    // frame_start marks the window corner pixel
    typedef struct packed {
        logic [`DFD_PIXEL_W-1:0] pixel;
        logic                    frame_start;
    } crop_beat_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_HEADER,
        SER_PIXELS
    } ser_state_e;

endpackage

`default_nettype wire

/* source/dfd_preview_cfg.svh */
`ifndef DFD_PREVIEW_CFG_SVH
`define DFD_PREVIEW_CFG_SVH

////////////////////
// frame geometry

// raw frame as delivered by the camera pair
`define DFD_RAW_WIDTH  512
`define DFD_RAW_HEIGHT 480

// preview window size
`define DFD_ROI_WIDTH  490
`define DFD_ROI_HEIGHT 450

`define DFD_COORD_W 16
`define DFD_PIXEL_W 8

////////////////////
// host side

`define DFD_CMD_BYTES  6
// ASCII "BIVFRAME" sent most significant byte first
`define DFD_MAGIC      64'h42_49_56_46_52_41_4D_45
`define DFD_FIFO_DEPTH 16

`endif
